// ==== hdl/sim_sram_params.svh ====
/*
 * Simulation SRAM parameters.
 * Bus widths, SRAM depth, outstanding limit and read-error default.
 */
`ifndef SIM_SRAM_PARAMS_SVH
`define SIM_SRAM_PARAMS_SVH

// Bus address and data width, data width is a multiple of 8.
`define SIM_SRAM_AW 32
`define SIM_SRAM_DW 32

// Number of SRAM words, sets the window size in bytes as depth times 4.
`define SIM_SRAM_DEPTH 16

// In-flight requests allowed through the steer.
`define SIM_SRAM_OUTSTANDING 2

// Reads return stored data unless this is set.
`define SIM_SRAM_ERR_ON_READ 0

`endif

// ==== hdl/sim_sram_pkg.sv ====
/*
 * Simulation SRAM package.
 * Bus opcode and response-route types shared by the RTL and the testbench.
 */
package sim_sram_pkg;

  // Bus opcodes for both channels.
  // A channel uses Get, PutFullData and PutPartialData.
  // D channel uses AccessAck and AccessAckData.
  // The encodings are kept distinct so one type serves both channels.
  typedef enum logic [2:0] {
    PutFullData    = 3'd0,
    PutPartialData = 3'd1,
    AccessAck      = 3'd2,
    AccessAckData  = 3'd3,
    Get            = 3'd4
  } tl_opcode_e;

  // Destination of an accepted request.
  // The steer keeps one entry per outstanding request to restore order.
  typedef enum logic {
    RouteSram = 1'b0,
    RouteOut  = 1'b1
  } tl_route_e;

endpackage

// ==== hdl/tl_if.sv ====
/*
 * Simplified TileLink-UL bus interface.
 * Carries the A request channel and the D response channel.
 */
`timescale 1ns/10ps
`include "sim_sram_params.svh"

interface tl_if #(
  parameter int AddrWidth = `SIM_SRAM_AW,
  parameter int DataWidth = `SIM_SRAM_DW
) (
  input logic clk_i,
  input logic rst_ni
);
  import sim_sram_pkg::*;

  // A channel.
  logic                   a_valid;
  logic                   a_ready;
  tl_opcode_e             a_opcode;
  logic [AddrWidth-1:0]   a_address;
  logic [DataWidth-1:0]   a_data;
  logic [DataWidth/8-1:0] a_mask;

  // D channel.
  logic                   d_valid;
  logic                   d_ready;
  tl_opcode_e             d_opcode;
  logic [DataWidth-1:0]   d_data;
  logic                   d_error;

  modport host (
    input  clk_i, rst_ni,
    output a_valid, a_opcode, a_address, a_data, a_mask, d_ready,
    input  a_ready, d_valid, d_opcode, d_data, d_error
  );

  modport device (
    input  clk_i, rst_ni,
    input  a_valid, a_opcode, a_address, a_data, a_mask, d_ready,
    output a_ready, d_valid, d_opcode, d_data, d_error
  );

endinterface

// ==== hdl/sram_1p.sv ====
/*
 * Single-port SRAM.
 * Bit-masked write, read data registered one cycle after the request.
 */
`timescale 1ns/10ps
`include "sim_sram_params.svh"

module sram_1p #(
  parameter int Depth = `SIM_SRAM_DEPTH
) (
  input  logic                     clk_i,
  input  logic                     req_i,
  input  logic                     write_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  logic [`SIM_SRAM_DW-1:0]  wdata_i,
  input  logic [`SIM_SRAM_DW-1:0]  wmask_i,
  output logic [`SIM_SRAM_DW-1:0]  rdata_o
);

  localparam int DW = `SIM_SRAM_DW;

  logic [DW-1:0] mem [Depth];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (write_i) begin
        // Only bits set in the mask take the new value.
        mem[addr_i] <= (mem[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
      end else begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// ==== hdl/tl_sram_adapter.sv ====
/*
 * Bus to SRAM adapter.
 * Turns each accepted request into one SRAM access and queues the
 * responses in a two-entry FIFO, with a strobe for every write.
 */
`timescale 1ns/10ps
`include "sim_sram_params.svh"

module tl_sram_adapter #(
  parameter bit ErrOnRead = `SIM_SRAM_ERR_ON_READ,
  parameter int Depth     = `SIM_SRAM_DEPTH
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  tl_if.device                          bus,

  output logic                          sram_req_o,
  output logic                          sram_we_o,
  output logic [$clog2(Depth)-1:0]      sram_addr_o,
  output logic [`SIM_SRAM_DW-1:0]       sram_wdata_o,
  output logic [`SIM_SRAM_DW-1:0]       sram_wmask_o,
  input  logic [`SIM_SRAM_DW-1:0]       sram_rdata_i,

  output logic                          wr_valid_o,
  output logic [$clog2(Depth)-1:0]      wr_index_o,
  output logic [`SIM_SRAM_DW-1:0]       wr_data_o,
  output logic [`SIM_SRAM_DW/8-1:0]     wr_mask_o
);
  import sim_sram_pkg::*;

  localparam int DW       = `SIM_SRAM_DW;
  localparam int NBytes   = DW / 8;
  localparam int IdxW     = $clog2(Depth);
  localparam int ByteOff  = $clog2(NBytes);
  localparam int RspDepth = 2;

  logic              accept;
  logic              is_write;
  logic [NBytes-1:0] byte_mask;
  logic [DW-1:0]     bit_mask;
  logic [IdxW-1:0]   index;

  logic              pend_q;
  logic              pend_read_q;
  tl_opcode_e        pend_op;
  logic [DW-1:0]     pend_data;
  logic              pend_err;

  tl_opcode_e        rsp_op_q   [RspDepth];
  logic [DW-1:0]     rsp_data_q [RspDepth];
  logic              rsp_err_q  [RspDepth];
  logic              rsp_wr_q;
  logic              rsp_rd_q;
  logic [1:0]        rsp_cnt_q;
  logic [2:0]        rsp_used;
  logic              d_fire;
  logic              rsp_push;
  logic              rsp_pop;

  assign accept   = bus.a_valid && bus.a_ready;
  assign is_write = (bus.a_opcode != Get);
  assign index    = bus.a_address[ByteOff +: IdxW];

  // PutFullData writes every byte whatever the mask says.
  assign byte_mask = (bus.a_opcode == PutFullData) ? '1 : bus.a_mask;

  always_comb begin
    for (int b = 0; b < NBytes; b++) begin
      bit_mask[8*b +: 8] = {8{byte_mask[b]}};
    end
  end

  // SRAM access in the cycle of acceptance.
  assign sram_req_o   = accept;
  assign sram_we_o    = is_write;
  assign sram_addr_o  = index;
  assign sram_wdata_o = bus.a_data;
  assign sram_wmask_o = bit_mask;

  assign wr_valid_o = accept && is_write;
  assign wr_index_o = index;
  assign wr_data_o  = bus.a_data;
  assign wr_mask_o  = byte_mask;

  // Room is needed for the response already in flight.
  assign rsp_used  = {1'b0, rsp_cnt_q} + {2'b00, pend_q};
  assign bus.a_ready = (rsp_used < 3'(RspDepth));

  // Response of the access made last cycle, read data is valid now.
  assign pend_op   = pend_read_q ? AccessAckData : AccessAck;
  assign pend_data = (pend_read_q && !ErrOnRead) ? sram_rdata_i : '0;
  assign pend_err  = pend_read_q && ErrOnRead;

  // Empty FIFO lets the fresh response through in the same cycle.
  assign bus.d_valid  = (rsp_cnt_q != '0) || pend_q;
  assign bus.d_opcode = (rsp_cnt_q != '0) ? rsp_op_q[rsp_rd_q]   : pend_op;
  assign bus.d_data   = (rsp_cnt_q != '0) ? rsp_data_q[rsp_rd_q] : pend_data;
  assign bus.d_error  = (rsp_cnt_q != '0) ? rsp_err_q[rsp_rd_q]  : pend_err;

  assign d_fire   = bus.d_valid && bus.d_ready;
  assign rsp_pop  = d_fire && (rsp_cnt_q != '0);
  assign rsp_push = pend_q && !(d_fire && (rsp_cnt_q == '0));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q    <= 1'b0;
      rsp_wr_q  <= 1'b0;
      rsp_rd_q  <= 1'b0;
      rsp_cnt_q <= '0;
    end else begin
      pend_q <= accept;
      if (rsp_push) begin
        rsp_wr_q <= ~rsp_wr_q;
      end
      if (rsp_pop) begin
        rsp_rd_q <= ~rsp_rd_q;
      end
      case ({rsp_push, rsp_pop})
        2'b10:   rsp_cnt_q <= rsp_cnt_q + 1'b1;
        2'b01:   rsp_cnt_q <= rsp_cnt_q - 1'b1;
        default: rsp_cnt_q <= rsp_cnt_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    pend_read_q <= !is_write;
    if (rsp_push) begin
      rsp_op_q[rsp_wr_q]   <= pend_op;
      rsp_data_q[rsp_wr_q] <= pend_data;
      rsp_err_q[rsp_wr_q]  <= pend_err;
    end
  end

endmodule

// ==== hdl/tl_window_steer.sv ====
/*
 * Address window steer.
 * Sends each A request to the SRAM or the outgoing port by address and
 * returns D responses to the host in request order.
 */
`timescale 1ns/10ps
`include "sim_sram_params.svh"

module tl_window_steer (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic [`SIM_SRAM_AW-1:0]       sram_base_i,

  input  logic                          host_a_valid_i,
  output logic                          host_a_ready_o,
  input  sim_sram_pkg::tl_opcode_e      host_a_opcode_i,
  input  logic [`SIM_SRAM_AW-1:0]       host_a_address_i,
  input  logic [`SIM_SRAM_DW-1:0]       host_a_data_i,
  input  logic [`SIM_SRAM_DW/8-1:0]     host_a_mask_i,
  output logic                          host_d_valid_o,
  input  logic                          host_d_ready_i,
  output sim_sram_pkg::tl_opcode_e      host_d_opcode_o,
  output logic [`SIM_SRAM_DW-1:0]       host_d_data_o,
  output logic                          host_d_error_o,

  output logic                          out_a_valid_o,
  input  logic                          out_a_ready_i,
  output sim_sram_pkg::tl_opcode_e      out_a_opcode_o,
  output logic [`SIM_SRAM_AW-1:0]       out_a_address_o,
  output logic [`SIM_SRAM_DW-1:0]       out_a_data_o,
  output logic [`SIM_SRAM_DW/8-1:0]     out_a_mask_o,
  input  logic                          out_d_valid_i,
  output logic                          out_d_ready_o,
  input  sim_sram_pkg::tl_opcode_e      out_d_opcode_i,
  input  logic [`SIM_SRAM_DW-1:0]       out_d_data_i,
  input  logic                          out_d_error_i,

  tl_if.host                            sram_bus
);
  import sim_sram_pkg::*;

  localparam int AW          = `SIM_SRAM_AW;
  localparam int Outstanding = `SIM_SRAM_OUTSTANDING;
  localparam int PtrW        = (Outstanding > 1) ? $clog2(Outstanding) : 1;
  localparam int CntW        = $clog2(Outstanding + 1);
  localparam logic [AW:0] WinBytes = (AW+1)'(`SIM_SRAM_DEPTH * (`SIM_SRAM_DW / 8));

  logic [AW:0]     win_end;
  logic            in_window;
  tl_route_e       a_route;
  tl_route_e       head_route;
  tl_route_e       route_q [Outstanding];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            fifo_full;
  logic            fifo_empty;
  logic            push;
  logic            pop;

  // Window check in one extra bit so a base near the top does not wrap.
  assign win_end   = {1'b0, sram_base_i} + WinBytes;
  assign in_window = ({1'b0, host_a_address_i} >= {1'b0, sram_base_i}) &&
                     ({1'b0, host_a_address_i} < win_end);
  assign a_route   = in_window ? RouteSram : RouteOut;

  assign fifo_full  = (count_q == CntW'(Outstanding));
  assign fifo_empty = (count_q == '0);
  assign head_route = route_q[rd_ptr_q];

  // A channel, combinational to the chosen destination.
  assign out_a_valid_o   = host_a_valid_i && !fifo_full && (a_route == RouteOut);
  assign out_a_opcode_o  = host_a_opcode_i;
  assign out_a_address_o = host_a_address_i;
  assign out_a_data_o    = host_a_data_i;
  assign out_a_mask_o    = host_a_mask_i;

  // The SRAM side sees the offset into the window.
  assign sram_bus.a_valid   = host_a_valid_i && !fifo_full && (a_route == RouteSram);
  assign sram_bus.a_opcode  = host_a_opcode_i;
  assign sram_bus.a_address = host_a_address_i - sram_base_i;
  assign sram_bus.a_data    = host_a_data_i;
  assign sram_bus.a_mask    = host_a_mask_i;

  assign host_a_ready_o = !fifo_full &&
                          ((a_route == RouteSram) ? sram_bus.a_ready : out_a_ready_i);

  // D channel, only the head destination may answer.
  assign sram_bus.d_ready = host_d_ready_i && !fifo_empty && (head_route == RouteSram);
  assign out_d_ready_o    = host_d_ready_i && !fifo_empty && (head_route == RouteOut);

  always_comb begin
    if (head_route == RouteSram) begin
      host_d_valid_o  = !fifo_empty && sram_bus.d_valid;
      host_d_opcode_o = sram_bus.d_opcode;
      host_d_data_o   = sram_bus.d_data;
      host_d_error_o  = sram_bus.d_error;
    end else begin
      host_d_valid_o  = !fifo_empty && out_d_valid_i;
      host_d_opcode_o = out_d_opcode_i;
      host_d_data_o   = out_d_data_i;
      host_d_error_o  = out_d_error_i;
    end
  end

  assign push = host_a_valid_i && host_a_ready_o;
  assign pop  = host_d_valid_o && host_d_ready_i;

  // Order FIFO pointers and fill level.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Outstanding - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Outstanding - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      route_q[wr_ptr_q] <= a_route;
    end
  end

endmodule

// ==== hdl/sim_sram.sv ====
/*
 * Simulation SRAM top level.
 * Sits on an outbound bus port, serves a run-time address window from a
 * local SRAM, passes all other requests on and shows window writes.
 */
`timescale 1ns/10ps
`include "sim_sram_params.svh"

module sim_sram (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [`SIM_SRAM_AW-1:0]             sram_base_i,

  input  logic                                host_a_valid_i,
  output logic                                host_a_ready_o,
  input  sim_sram_pkg::tl_opcode_e            host_a_opcode_i,
  input  logic [`SIM_SRAM_AW-1:0]             host_a_address_i,
  input  logic [`SIM_SRAM_DW-1:0]             host_a_data_i,
  input  logic [`SIM_SRAM_DW/8-1:0]           host_a_mask_i,
  output logic                                host_d_valid_o,
  input  logic                                host_d_ready_i,
  output sim_sram_pkg::tl_opcode_e            host_d_opcode_o,
  output logic [`SIM_SRAM_DW-1:0]             host_d_data_o,
  output logic                                host_d_error_o,

  output logic                                out_a_valid_o,
  input  logic                                out_a_ready_i,
  output sim_sram_pkg::tl_opcode_e            out_a_opcode_o,
  output logic [`SIM_SRAM_AW-1:0]             out_a_address_o,
  output logic [`SIM_SRAM_DW-1:0]             out_a_data_o,
  output logic [`SIM_SRAM_DW/8-1:0]           out_a_mask_o,
  input  logic                                out_d_valid_i,
  output logic                                out_d_ready_o,
  input  sim_sram_pkg::tl_opcode_e            out_d_opcode_i,
  input  logic [`SIM_SRAM_DW-1:0]             out_d_data_i,
  input  logic                                out_d_error_i,

  output logic                                sram_wr_valid_o,
  output logic [$clog2(`SIM_SRAM_DEPTH)-1:0]  sram_wr_index_o,
  output logic [`SIM_SRAM_DW-1:0]             sram_wr_data_o,
  output logic [`SIM_SRAM_DW/8-1:0]           sram_wr_mask_o
);

  localparam int IdxW = $clog2(`SIM_SRAM_DEPTH);

  logic                    sram_req;
  logic                    sram_we;
  logic [IdxW-1:0]         sram_addr;
  logic [`SIM_SRAM_DW-1:0] sram_wdata;
  logic [`SIM_SRAM_DW-1:0] sram_wmask;
  logic [`SIM_SRAM_DW-1:0] sram_rdata;

  // Bus between the steer and the adapter.
  tl_if #(
    .AddrWidth(`SIM_SRAM_AW),
    .DataWidth(`SIM_SRAM_DW)
  ) sram_bus (
    .clk_i,
    .rst_ni
  );

  tl_window_steer i_steer (
    .clk_i,
    .rst_ni,
    .sram_base_i,
    .host_a_valid_i,
    .host_a_ready_o,
    .host_a_opcode_i,
    .host_a_address_i,
    .host_a_data_i,
    .host_a_mask_i,
    .host_d_valid_o,
    .host_d_ready_i,
    .host_d_opcode_o,
    .host_d_data_o,
    .host_d_error_o,
    .out_a_valid_o,
    .out_a_ready_i,
    .out_a_opcode_o,
    .out_a_address_o,
    .out_a_data_o,
    .out_a_mask_o,
    .out_d_valid_i,
    .out_d_ready_o,
    .out_d_opcode_i,
    .out_d_data_i,
    .out_d_error_i,
    .sram_bus (sram_bus.host)
  );

  tl_sram_adapter #(
    .ErrOnRead(`SIM_SRAM_ERR_ON_READ),
    .Depth    (`SIM_SRAM_DEPTH)
  ) i_adapter (
    .clk_i,
    .rst_ni,
    .bus         (sram_bus.device),
    .sram_req_o  (sram_req),
    .sram_we_o   (sram_we),
    .sram_addr_o (sram_addr),
    .sram_wdata_o(sram_wdata),
    .sram_wmask_o(sram_wmask),
    .sram_rdata_i(sram_rdata),
    .wr_valid_o  (sram_wr_valid_o),
    .wr_index_o  (sram_wr_index_o),
    .wr_data_o   (sram_wr_data_o),
    .wr_mask_o   (sram_wr_mask_o)
  );

  sram_1p #(
    .Depth(`SIM_SRAM_DEPTH)
  ) i_sram (
    .clk_i,
    .req_i  (sram_req),
    .write_i(sram_we),
    .addr_i (sram_addr),
    .wdata_i(sram_wdata),
    .wmask_i(sram_wmask),
    .rdata_o(sram_rdata)
  );

endmodule

// ==== testbench/sim_sram_asserts.sv ====
/*
 * Window steer assertions.
 * Handshake stability, order FIFO bounds and response ordering.
 */
`timescale 1ns/10ps
`include "sim_sram_params.svh"

module sim_sram_asserts (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      host_a_valid_i,
  input logic                      host_a_ready_o,
  input sim_sram_pkg::tl_opcode_e  host_a_opcode_i,
  input logic [`SIM_SRAM_AW-1:0]   host_a_address_i,
  input logic [`SIM_SRAM_DW-1:0]   host_a_data_i,
  input logic [`SIM_SRAM_DW/8-1:0] host_a_mask_i,
  input logic                      host_d_valid_o,
  input logic                      host_d_ready_i,
  input sim_sram_pkg::tl_opcode_e  host_d_opcode_o,
  input logic [`SIM_SRAM_DW-1:0]   host_d_data_o,
  input logic                      host_d_error_o,
  input logic                      out_a_valid_o,
  input sim_sram_pkg::tl_route_e   head_route
);
  import sim_sram_pkg::*;

  localparam int Outstanding = `SIM_SRAM_OUTSTANDING;
  localparam int Slots       = Outstanding + 1;

  logic      a_fire;
  logic      d_fire;
  int        wr_idx;
  int        rd_idx;
  int        inflight;
  tl_route_e order_q [Slots];

  assign a_fire = host_a_valid_i && host_a_ready_o;
  assign d_fire = host_d_valid_o && host_d_ready_i;

  // Reference order model built from the host handshakes alone.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx   <= 0;
      rd_idx   <= 0;
      inflight <= 0;
    end else begin
      if (a_fire) begin
        order_q[wr_idx] <= out_a_valid_o ? RouteOut : RouteSram;
        wr_idx <= (wr_idx + 1) % Slots;
      end
      if (d_fire) begin
        rd_idx <= (rd_idx + 1) % Slots;
      end
      inflight <= inflight + int'(a_fire) - int'(d_fire);
    end
  end

  // A stalled request keeps its payload.
  a_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_a_valid_i && !host_a_ready_o |=> host_a_valid_i &&
      $stable({host_a_opcode_i, host_a_address_i, host_a_data_i, host_a_mask_i}))
    else $error("Host A request changed before it was accepted");

  d_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_d_valid_o && !host_d_ready_i |=> host_d_valid_o &&
      $stable({host_d_opcode_o, host_d_data_o, host_d_error_o}))
    else $error("Host D response changed before it was accepted");

  no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (inflight >= 0) && (inflight <= Outstanding))
    else $error("Order FIFO overflow");

  d_needs_entry: assert property (@(posedge clk_i) disable iff (!rst_ni)
    host_d_valid_o |-> (inflight != 0))
    else $error("Host D valid with no request outstanding");

  // The steer's head must name the destination of the oldest request.
  in_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (inflight != 0) |-> (head_route == order_q[rd_idx]))
    else $error("Order FIFO head does not match the oldest request");

endmodule

bind tl_window_steer sim_sram_asserts i_sim_sram_asserts (.*);

// ==== testbench/tb_sim_sram.sv ====
/*
 * Testbench for the simulation SRAM.
 * Replays the test file on the host port, models the downstream device
 * and checks responses, routes and window write strobes.
 */
`timescale 1ns/10ps
`include "sim_sram_params.svh"

module tb_sim_sram;
  import sim_sram_pkg::*;

  localparam int AW            = `SIM_SRAM_AW;
  localparam int DW            = `SIM_SRAM_DW;
  localparam int MW            = DW / 8;
  localparam int IdxW          = $clog2(`SIM_SRAM_DEPTH);
  localparam int MaxTests      = 64;
  localparam int CyclesPerTest = 20;
  localparam logic [AW-1:0] Base = 32'h1000_0000;

  logic            clk_i;
  logic            rst_ni;
  logic [AW-1:0]   sram_base_i;
  logic            host_a_valid_i;
  logic            host_a_ready_o;
  tl_opcode_e      host_a_opcode_i;
  logic [AW-1:0]   host_a_address_i;
  logic [DW-1:0]   host_a_data_i;
  logic [MW-1:0]   host_a_mask_i;
  logic            host_d_valid_o;
  logic            host_d_ready_i;
  tl_opcode_e      host_d_opcode_o;
  logic [DW-1:0]   host_d_data_o;
  logic            host_d_error_o;
  logic            out_a_valid_o;
  logic            out_a_ready_i;
  tl_opcode_e      out_a_opcode_o;
  logic [AW-1:0]   out_a_address_o;
  logic [DW-1:0]   out_a_data_o;
  logic [MW-1:0]   out_a_mask_o;
  logic            out_d_valid_i;
  logic            out_d_ready_o;
  tl_opcode_e      out_d_opcode_i;
  logic [DW-1:0]   out_d_data_i;
  logic            out_d_error_i;
  logic            sram_wr_valid_o;
  logic [IdxW-1:0] sram_wr_index_o;
  logic [DW-1:0]   sram_wr_data_o;
  logic [MW-1:0]   sram_wr_mask_o;

  // Test table, one entry per line of the data file.
  string           t_name  [MaxTests];
  tl_opcode_e      t_op    [MaxTests];
  logic [AW-1:0]   t_addr  [MaxTests];
  logic [DW-1:0]   t_wdata [MaxTests];
  logic [MW-1:0]   t_mask  [MaxTests];
  logic [DW-1:0]   t_rdata [MaxTests];
  logic            t_err   [MaxTests];
  tl_route_e       t_route [MaxTests];
  tl_route_e       seen_route [MaxTests];
  logic            altered [MaxTests];

  int              n_tests;
  int              passed;
  int              failed;
  int              other_errs;
  int              done;
  bit              loaded;
  int              rsp_q[$];
  int              strobe_q[$];
  logic [AW-1:0]   dn_addr_q[$];
  logic            dn_read_q[$];
  logic [31:0]     lfsr;
  int              dn_wait;
  bit              dn_showing;
  bit              dn_timed;

  sim_sram i_sim_sram (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      val = (val << 1) | int'(lfsr[0]);
    end
  endtask

  function automatic tl_opcode_e opcode_from_name(input string s);
    if (s == "get") return Get;
    if (s == "putpart") return PutPartialData;
    return PutFullData;
  endfunction

  task automatic load_tests();
    int            fd;
    int            cnt;
    string         line;
    string         name_s;
    string         op_s;
    string         rt_s;
    logic [AW-1:0] addr;
    logic [DW-1:0] wdata;
    logic [DW-1:0] rdata;
    logic [MW-1:0] mask;
    logic          err;
    n_tests = 0;
    fd = $fopen("testbench/sim_sram_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open testbench/sim_sram_tests.txt");
      other_errs++;
      return;
    end
    while (!$feof(fd) && n_tests < MaxTests) begin
      cnt = $fgets(line, fd);
      if (cnt > 1 && line[0] != "#") begin
        cnt = $sscanf(line, "%s %s %h %h %h %h %h %s",
                      name_s, op_s, addr, wdata, mask, rdata, err, rt_s);
        if (cnt == 8) begin
          t_name[n_tests]  = name_s;
          t_op[n_tests]    = opcode_from_name(op_s);
          t_addr[n_tests]  = addr;
          t_wdata[n_tests] = wdata;
          t_mask[n_tests]  = mask;
          t_rdata[n_tests] = rdata;
          t_err[n_tests]   = err;
          t_route[n_tests] = (rt_s == "out") ? RouteOut : RouteSram;
          n_tests++;
        end else begin
          $display("Malformed line in the test file: %s", line);
          other_errs++;
        end
      end
    end
    $fclose(fd);
  endtask

  // Issues the requests back to back, each held until the DUT takes it.
  task automatic run_requests();
    for (int i = 0; i < n_tests; i++) begin
      host_a_valid_i   <= 1'b1;
      host_a_opcode_i  <= t_op[i];
      host_a_address_i <= t_addr[i];
      host_a_data_i    <= t_wdata[i];
      host_a_mask_i    <= t_mask[i];
      if (t_route[i] == RouteSram && t_op[i] != Get) begin
        strobe_q.push_back(i);
      end
      do @(posedge clk_i); while (!host_a_ready_o);
      seen_route[i] = out_a_valid_o ? RouteOut : RouteSram;
      altered[i] = out_a_valid_o && (out_a_opcode_o != t_op[i] ||
                   out_a_address_o != t_addr[i] || out_a_data_o != t_wdata[i] ||
                   out_a_mask_o != t_mask[i]);
      rsp_q.push_back(i);
    end
    host_a_valid_i <= 1'b0;
  endtask

  // One line per finished test, the first mismatch decides it.
  task automatic check_response(input int k);
    tl_opcode_e exp_op;
    exp_op = (t_op[k] == Get) ? AccessAckData : AccessAck;
    if (host_d_opcode_o != exp_op) begin
      $display("FAIL %s: opcode expected %s actual %s", t_name[k], exp_op.name(),
               host_d_opcode_o.name());
      failed++;
    end else if (t_op[k] == Get && host_d_data_o != t_rdata[k]) begin
      $display("FAIL %s: data expected %h actual %h", t_name[k], t_rdata[k], host_d_data_o);
      failed++;
    end else if (host_d_error_o != t_err[k]) begin
      $display("FAIL %s: error expected %b actual %b", t_name[k], t_err[k], host_d_error_o);
      failed++;
    end else if (seen_route[k] != t_route[k]) begin
      $display("FAIL %s: route expected %s actual %s", t_name[k], t_route[k].name(),
               seen_route[k].name());
      failed++;
    end else if (altered[k]) begin
      $display("FAIL %s: the request was changed on its way to the outgoing port", t_name[k]);
      failed++;
    end else begin
      $display("PASS %s", t_name[k]);
      passed++;
    end
  endtask

  // Index is the word offset from the base, full writes strobe every byte.
  task automatic check_strobe();
    int                    k;
    logic [AW-1:0]         off;
    logic [MW-1:0]         exp_mask;
    logic [IdxW+DW+MW-1:0] exp_s;
    logic [IdxW+DW+MW-1:0] act_s;
    if (!sram_wr_valid_o) return;
    if (strobe_q.size() == 0) begin
      $display("Write strobe for index %0d with no window write pending", sram_wr_index_o);
      other_errs++;
      return;
    end
    k = strobe_q.pop_front();
    off = t_addr[k] - Base;
    exp_mask = (t_op[k] == PutFullData) ? {MW{1'b1}} : t_mask[k];
    exp_s = {off[IdxW+1:2], t_wdata[k], exp_mask};
    act_s = {sram_wr_index_o, sram_wr_data_o, sram_wr_mask_o};
    if (act_s != exp_s) begin
      $display("FAIL %s: write strobe expected %h actual %h", t_name[k], exp_s, act_s);
      other_errs++;
    end
  endtask

  // Downstream device, answers after 0 to 3 cycles.
  task automatic model_downstream();
    if (out_a_valid_o && out_a_ready_i) begin
      dn_addr_q.push_back(out_a_address_o);
      dn_read_q.push_back(out_a_opcode_o == Get);
    end
    if (out_d_valid_i && out_d_ready_o) begin
      void'(dn_addr_q.pop_front());
      void'(dn_read_q.pop_front());
      out_d_valid_i <= 1'b0;
      dn_showing = 1'b0;
    end else if (!dn_showing && dn_addr_q.size() != 0) begin
      if (!dn_timed) begin
        draw_bits(2, dn_wait);
        dn_timed = 1'b1;
      end
      if (dn_wait == 0) begin
        out_d_valid_i  <= 1'b1;
        out_d_opcode_i <= dn_read_q[0] ? AccessAckData : AccessAck;
        out_d_data_i   <= dn_read_q[0] ? (dn_addr_q[0] ^ 32'hA5A5_0000) : '0;
        dn_showing = 1'b1;
        dn_timed   = 1'b0;
      end else begin
        dn_wait--;
      end
    end
  endtask

  // Host response side, downstream model and strobe monitor.
  initial begin
    int k;
    int bitv;
    wait (loaded && rst_ni === 1'b1);
    forever begin
      @(posedge clk_i);
      if (host_d_valid_o && host_d_ready_i) begin
        if (rsp_q.size() == 0) begin
          $display("Response received with no request outstanding");
          other_errs++;
        end else begin
          k = rsp_q.pop_front();
          check_response(k);
          done++;
        end
      end
      check_strobe();
      model_downstream();
      draw_bits(1, bitv);
      host_d_ready_i <= (bitv != 0);
    end
  end

  initial begin
    int cycles;
    int limit;
    cycles = 0;
    wait (loaded);
    limit = (n_tests + 1) * CyclesPerTest;
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d of %0d responses received", cycles, done, n_tests);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_ni           = 1'b0;
    sram_base_i      = Base;
    host_a_valid_i   = 1'b0;
    host_a_opcode_i  = Get;
    host_a_address_i = '0;
    host_a_data_i    = '0;
    host_a_mask_i    = '0;
    host_d_ready_i   = 1'b0;
    out_a_ready_i    = 1'b0;
    out_d_valid_i    = 1'b0;
    out_d_opcode_i   = AccessAck;
    out_d_data_i     = '0;
    out_d_error_i    = 1'b0;
    lfsr             = 32'h7186;
    load_tests();
    loaded = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_ni        <= 1'b1;
    out_a_ready_i <= 1'b1;
    @(posedge clk_i);
    // Outputs must be idle before the first request.
    if (host_d_valid_o !== 1'b0 || out_a_valid_o !== 1'b0 || sram_wr_valid_o !== 1'b0) begin
      $display("FAIL reset_idle: expected 000 actual %b%b%b", host_d_valid_o, out_a_valid_o,
               sram_wr_valid_o);
      failed++;
    end else begin
      $display("PASS reset_idle");
      passed++;
    end
    run_requests();
    wait (done == n_tests);
    repeat (4) @(posedge clk_i);
    if (strobe_q.size() != 0) begin
      $display("%0d window writes produced no write strobe", strobe_q.size());
      other_errs++;
    end
    if (n_tests == 0) begin
      $display("No tests were loaded");
      other_errs++;
    end
    $display("Tests run %0d, passed %0d, failed %0d, other errors %0d", n_tests + 1, passed,
             failed, other_errs);
    if (failed == 0 && other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== testbench/sim_sram_tests.txt ====
# name op addr wdata mask rdata err route
# op is get, putfull or putpart; numbers are hex; route is sram or out
wr_full_w0     putfull 10000000 cafef00d f 00000000 0 sram
rd_full_w0     get     10000000 00000000 0 cafef00d 0 sram
wr_full_w1     putfull 10000004 11223344 3 00000000 0 sram
wr_part_w1     putpart 10000004 aabbccdd 5 00000000 0 sram
rd_part_w1     get     10000004 00000000 0 11bb33dd 0 sram
wr_full_top    putfull 1000003c 0badc0de f 00000000 0 sram
wr_part_top    putpart 1000003c 12345678 a 00000000 0 sram
rd_part_top    get     1000003c 00000000 0 12ad56de 0 sram
rd_out_below   get     0ffffffc 00000000 0 aa5afffc 0 out
wr_out_below   putfull 0ffffffc 55aa55aa f 00000000 0 out
rd_out_end     get     10000040 00000000 0 b5a50040 0 out
wr_out_end     putpart 10000040 01020304 6 00000000 0 out
mix_wr_w2      putfull 10000008 deadbeef f 00000000 0 sram
mix_rd_out     get     20000010 00000000 0 85a50010 0 out
mix_rd_w2      get     10000008 00000000 0 deadbeef 0 sram
mix_wr_out     putfull 30001234 0f0f0f0f f 00000000 0 out
mix_rd_w0      get     10000000 00000000 0 cafef00d 0 sram
mix_rd_out2    get     30001234 00000000 0 95a51234 0 out
mix_rd_top     get     1000003c 00000000 0 12ad56de 0 sram
mix_rd_w1      get     10000004 00000000 0 11bb33dd 0 sram

// ==== flist.f ====
+incdir+hdl
hdl/sim_sram_pkg.sv
hdl/tl_if.sv
hdl/sram_1p.sv
hdl/tl_sram_adapter.sv
hdl/tl_window_steer.sv
hdl/sim_sram.sv
testbench/sim_sram_asserts.sv
testbench/tb_sim_sram.sv

// ==== Makefile ====
# Verilator lint and simulation of the simulation SRAM testbench.
VERILATOR  ?= verilator
TOP        := tb_sim_sram
FLIST      := flist.f
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
BIN        := $(OBJ_DIR)/V$(TOP)
LOG        := sim.log
SRCS       := $(shell grep -v '^+' $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FLIST) hdl/sim_sram_params.svh
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
